// File: sources.f
video_pkg.sv
pixel_if.sv
video_mode_detect.sv
scan_doubler.sv
lcd_timing.sv
audio_i2s.sv
video_apb_regs.sv
video_top.sv
tb_video_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module tb_video_top -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
   exit 1
fi
exit 0

// File: tb_video_top.sv
// testbench for the video and audio output stage, run through sources.f with run.sh
module tb_video_top;
   import video_pkg::*;

   localparam int H_ACT = 40;
   localparam int V_ACT = 20;
   localparam int LINE_CLKS = 128;
   // 14 frames of at most 450 lines, doubled for margin, 40 time units per clock
   localparam longint TIMEOUT = 64'd14 * 450 * LINE_CLKS * 2 * 40;

   logic clk_pixel = 1'b0;
   logic rst_n, hs_in_n, vs_in_n, psel, penable, pwrite;
   logic [3:0] r_in, g_in, b_in, paddr;
   logic signed [17:0] audio_l, audio_r;
   logic [31:0] pwdata, prdata;
   logic pready, pslverr, vreset, lcd_clk, lcd_hs_n, lcd_vs_n, lcd_de;
   logic [5:0] lcd_r, lcd_g, lcd_b;
   logic hp_bck, hp_ws, hp_din, pa_en;

   int err_apb = 0, err_mode = 0, err_pix = 0, err_de = 0, err_audio = 0;
   int line_idx = 0, line_pos = 0, ctrl_line = 0, frame_lines = 262;
   int prev_lines = 0, frame_starts = 0, exp_pulses = 0, vreset_cnt = 0;
   int de_cnt = 0, de_frames = 0, col = 0, audio_checks = 0;
   logic [11:0] cur_col = '0, prev_col = '0;
   logic [3:0] ctrl_val = '0;
   logic audio_en = 1'b0;
   vmode_t exp_mode = VMODE_PAL;

   video_top #(.LINE_AW(7), .H_ACTIVE(H_ACT), .V_ACTIVE(V_ACT), .AUDIO_DIV(3)) u_dut (.*);

   initial begin
      forever #20 clk_pixel = ~clk_pixel;
   end

   initial begin
      #(TIMEOUT);
      $display("watchdog expired, the run did not reach its end in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // lcd clock follows the pixel clock, compared halfway through each phase
   initial begin
      forever begin
         @(clk_pixel);
         #10;
         assert (lcd_clk == clk_pixel) else begin
            $display("error %0t: lcd_clk %b differs from clk_pixel", $time, lcd_clk);
            err_de++;
         end
      end
   end

   function automatic logic [5:0] widen(input logic [3:0] c);
      return {c, c[3:2]};
   endfunction

   function automatic logic [17:0] shade(input logic [11:0] c, input logic [1:0] lvl);
      logic [5:0] ch [3];
      ch[0] = widen(c[11:8]);
      ch[1] = widen(c[7:4]);
      ch[2] = widen(c[3:0]);
      for (int i = 0; i < 3; i++) begin
         if (lvl == 2'd1) ch[i] = ch[i] - (ch[i] >> 2);
         else if (lvl == 2'd2) ch[i] = ch[i] - (ch[i] >> 1);
         else if (lvl == 2'd3) ch[i] = ch[i] - (ch[i] >> 1) - (ch[i] >> 2);
      end
      return {ch[0], ch[1], ch[2]};
   endfunction

   function automatic vmode_t mode_of(input int lines);
      if (lines <= int'(NTSC_MAX_LINES)) return VMODE_NTSC;
      if (lines <= int'(PAL_MAX_LINES)) return VMODE_PAL;
      return VMODE_HIGH;
   endfunction

   function automatic logic [15:0] audio_word(input logic signed [17:0] l,
                                              input logic signed [17:0] r,
                                              input logic [1:0] v);
      int s [2];
      int sum;
      s[0] = int'(l) >>> 2;
      s[1] = int'(r) >>> 2;
      sum = 0;
      for (int i = 0; i < 2; i++) begin
         if (s[i] > 32767) s[i] = 32767;
         if (s[i] < -32768) s[i] = -32768;
         if (v == 2'd0) s[i] = 0;
         else if (v == 2'd1) s[i] = s[i] >>> 2;
         else if (v == 2'd2) s[i] = s[i] >>> 1;
         sum = sum + s[i];
      end
      return 16'(sum + 32768);
   endfunction

   task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err, output logic rdy);
      @(posedge clk_pixel);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk_pixel);
      penable <= 1'b1;
      @(negedge clk_pixel);
      rdata = prdata;
      err   = pslverr;
      rdy   = pready;
      @(posedge clk_pixel);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic ctrl_write(input logic [3:0] val);
      logic [31:0] rd;
      logic err, rdy;
      ctrl_line = line_idx;
      apb_xfer(1'b1, 4'd0, {$urandom} << 4 | 32'(val), rd, err, rdy);
      ctrl_val = val;
   endtask

   // one frame per pass, vsync low for the first three lines
   task automatic run_video();
      int lines;
      vmode_t nm;
      forever begin
         lines = frame_lines;
         for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < LINE_CLKS; p++) begin
               @(posedge clk_pixel);
               if (p == 0) begin
                  if (l == 0) begin
                     nm = mode_of(prev_lines);
                     if (nm != exp_mode) exp_pulses++;
                     exp_mode = nm;
                     prev_lines = lines;
                     frame_starts++;
                  end
                  line_idx++;
                  prev_col = cur_col;
                  cur_col = 12'($urandom);
                  r_in <= cur_col[11:8];
                  g_in <= cur_col[7:4];
                  b_in <= cur_col[3:0];
               end
               hs_in_n <= (p >= 16);
               vs_in_n <= (l >= 3);
               line_pos = p;
            end
         end
      end
   endtask

   task automatic wait_frames(input int n);
      int target;
      target = frame_starts + n;
      while (frame_starts < target) @(posedge clk_pixel);
   endtask

   // all checks sample on the falling edge where DUT outputs are settled
   initial begin
      logic hs_p, vs_p, de_p, bck_p, ws_p;
      logic [15:0] sr;
      logic [17:0] exp_pix;
      hs_p = 1'b1;
      vs_p = 1'b1;
      de_p = 1'b0;
      bck_p = 1'b0;
      ws_p = 1'b0;
      sr = '0;
      forever begin
         @(negedge clk_pixel);
         if (vreset) vreset_cnt++;
         if (line_idx >= 3 && line_idx > ctrl_line + 2 && (line_pos == 32 || line_pos == 96)) begin
            exp_pix = shade(prev_col, (line_pos == 96) ? ctrl_val[1:0] : 2'd0);
            assert ({lcd_r, lcd_g, lcd_b} == exp_pix) else begin
               $display("error %0t: pixel %h expected %h at line %0d pos %0d", $time,
                        {lcd_r, lcd_g, lcd_b}, exp_pix, line_idx, line_pos);
               err_pix++;
            end
         end
         if (lcd_vs_n && !vs_p) begin
            if (de_frames > 0) begin
               assert (de_cnt == H_ACT * V_ACT) else begin
                  $display("error %0t: %0d de cycles in frame", $time, de_cnt);
                  err_de++;
               end
            end
            de_frames++;
            de_cnt = 0;
         end
         col = (lcd_hs_n && !hs_p) ? 0 : col + 1;
         if (lcd_de) de_cnt++;
         if (lcd_de && !de_p) begin
            assert (col >= int'(H_START_TABLE[exp_mode])) else begin
               $display("error %0t: de rose at column %0d", $time, col);
               err_de++;
            end
         end
         if (hp_bck && !bck_p) sr = {sr[14:0], hp_din};
         if (hp_ws != ws_p && audio_en) begin
            audio_checks++;
            assert (sr == audio_word(audio_l, audio_r, ctrl_val[3:2])) else begin
               $display("error %0t: audio word %h expected %h", $time, sr,
                        audio_word(audio_l, audio_r, ctrl_val[3:2]));
               err_audio++;
            end
         end
         hs_p = lcd_hs_n;
         vs_p = lcd_vs_n;
         de_p = lcd_de;
         bck_p = hp_bck;
         ws_p = hp_ws;
      end
   end

   initial begin
      logic [31:0] rd, wd;
      logic err, rdy;
      void'($urandom(32'h5867));
      rst_n = 1'b0;
      {hs_in_n, vs_in_n} = 2'b11;
      {r_in, g_in, b_in} = '0;
      {psel, penable, pwrite, paddr, pwdata} = '0;
      audio_l = '0;
      audio_r = '0;
      repeat (10) @(posedge clk_pixel);
      rst_n <= 1'b1;
      for (int i = 0; i < 4; i++) begin
         wd = $urandom;
         apb_xfer(1'b1, 4'd0, wd, rd, err, rdy);
         apb_xfer(1'b0, 4'd0, 32'd0, rd, err, rdy);
         assert (rd == 32'(wd[3:0]) && !err) else begin
            $display("error %0t: ctrl read %h after writing %h", $time, rd, wd);
            err_apb++;
         end
      end
      ctrl_val = wd[3:0];
      apb_xfer(1'b0, 4'd4, 32'd0, rd, err, rdy);
      assert (rd == 32'(exp_mode)) else begin
         $display("error %0t: status read %h after reset", $time, rd);
         err_apb++;
      end
      for (int i = 0; i < 2; i++) begin
         apb_xfer(i[0], 4'd8, 32'hf, rd, err, rdy);
         assert (err && rdy) else begin
            $display("error %0t: no pslverr on unmapped address", $time);
            err_apb++;
         end
      end
      apb_xfer(1'b0, 4'd0, 32'd0, rd, err, rdy);
      assert (rd == 32'(ctrl_val)) else begin
         $display("error %0t: ctrl changed by an unmapped write", $time);
         err_apb++;
      end
      fork
         run_video();
      join_none
      for (int i = 0; i < 4; i++) begin
         frame_lines = (i == 1) ? 312 : (i == 2) ? 450 : 262;
         wait_frames(3);
         apb_xfer(1'b0, 4'd4, 32'd0, rd, err, rdy);
         assert (rd == 32'(mode_of(frame_lines))) else begin
            $display("error %0t: status %h for %0d line frames", $time, rd, frame_lines);
            err_mode++;
         end
      end
      for (int s = 0; s < 4; s++) begin
         ctrl_write({2'd3, 2'(s)});
         repeat (20 * LINE_CLKS) @(posedge clk_pixel);
      end
      for (int v = 0; v < 4; v++) begin
         audio_l <= 18'($urandom);
         audio_r <= 18'($urandom);
         ctrl_write({2'(v), 2'd2});
         repeat (3) @(posedge hp_ws);
         audio_en = 1'b1;
         repeat (2) @(posedge hp_ws);
         audio_en = 1'b0;
      end
      assert (vreset_cnt == exp_pulses && audio_checks > 0 && pa_en) else begin
         $display("error %0t: vreset %0d pulses, expected %0d, audio checks %0d", $time,
                  vreset_cnt, exp_pulses, audio_checks);
         err_mode++;
      end
      $display("errors: apb %0d mode %0d pixel %0d de %0d audio %0d", err_apb, err_mode,
               err_pix, err_de, err_audio);
      if (err_apb + err_mode + err_pix + err_de + err_audio == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: video_top.sv
// video and audio output stage top, drives the rgb lcd and the i2s dac from core video and audio
module video_top #(
   parameter int LINE_AW   = 11,
   parameter int H_ACTIVE  = 800,
   parameter int V_ACTIVE  = 480,
   parameter int AUDIO_DIV = 20
) (
   input  logic               clk_pixel,
   input  logic               rst_n,
   input  logic               hs_in_n,
   input  logic               vs_in_n,
   input  logic [3:0]         r_in,
   input  logic [3:0]         g_in,
   input  logic [3:0]         b_in,
   input  logic signed [17:0] audio_l,
   input  logic signed [17:0] audio_r,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [3:0]         paddr,
   input  logic [31:0]        pwdata,
   output logic [31:0]        prdata,
   output logic               pready,
   output logic               pslverr,
   output logic               vreset,
   output logic               lcd_clk,
   output logic               lcd_hs_n,
   output logic               lcd_vs_n,
   output logic               lcd_de,
   output logic [5:0]         lcd_r,
   output logic [5:0]         lcd_g,
   output logic [5:0]         lcd_b,
   output logic               hp_bck,
   output logic               hp_ws,
   output logic               hp_din,
   output logic               pa_en
);
   import video_pkg::*;

   vmode_t    vmode;
   scanline_t scanlines;
   volume_t   volume;

   pixel_if u_pix ();

   video_mode_detect u_mode (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .hs_n      (hs_in_n),
      .vs_n      (vs_in_n),
      .vmode     (vmode),
      .vreset    (vreset)
   );

   scan_doubler #(.LINE_AW(LINE_AW)) u_sd (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .hs_in_n   (hs_in_n),
      .vs_in_n   (vs_in_n),
      .r_in      (r_in),
      .g_in      (g_in),
      .b_in      (b_in),
      .scanlines (scanlines),
      .out       (u_pix.source)
   );

   lcd_timing #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_lcd (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .in        (u_pix.sink),
      .vmode     (vmode),
      .lcd_clk   (lcd_clk),
      .lcd_hs_n  (lcd_hs_n),
      .lcd_vs_n  (lcd_vs_n),
      .lcd_de    (lcd_de),
      .lcd_r     (lcd_r),
      .lcd_g     (lcd_g),
      .lcd_b     (lcd_b)
   );

   audio_i2s #(.AUDIO_DIV(AUDIO_DIV)) u_audio (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .audio_l   (audio_l),
      .audio_r   (audio_r),
      .volume    (volume),
      .hp_bck    (hp_bck),
      .hp_ws     (hp_ws),
      .hp_din    (hp_din),
      .pa_en     (pa_en)
   );

   video_apb_regs u_regs (
      .clk_pixel (clk_pixel),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .vmode     (vmode),
      .scanlines (scanlines),
      .volume    (volume)
   );

endmodule

// File: video_apb_regs.sv
// zero-wait apb slave with the ctrl (scanlines, volume) and status (vmode) registers
module video_apb_regs (
   input  logic                 clk_pixel,
   input  logic                 rst_n,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [3:0]           paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   input  video_pkg::vmode_t    vmode,
   output video_pkg::scanline_t scanlines,
   output video_pkg::volume_t   volume
);

   logic       access;
   logic       sel_ctrl;
   logic       sel_status;
   logic [3:0] ctrl;

   assign pready     = 1'b1;
   assign access     = psel & penable;
   assign sel_ctrl   = (paddr == 4'd0);
   assign sel_status = (paddr == 4'd4);
   assign pslverr    = access & ~(sel_ctrl | sel_status);

   assign prdata = sel_ctrl   ? {28'd0, ctrl} :
                   sel_status ? {30'd0, vmode} : 32'd0;

   assign scanlines = ctrl[1:0];
   assign volume    = ctrl[3:2];

   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         ctrl <= '0;
      end else if (access && pwrite && sel_ctrl) begin
         ctrl <= pwdata[3:0];
      end
   end

   a_apb_stable: assert property (@(posedge clk_pixel) disable iff (!rst_n)
      (psel && !penable) |=> ($stable(paddr) && $stable(pwrite)));

endmodule

// File: audio_i2s.sv
// saturates, scales and mixes stereo audio to mono and sends it to the headphone dac as i2s
module audio_i2s #(
   parameter int AUDIO_DIV = 20
) (
   input  logic               clk_pixel,
   input  logic               rst_n,
   input  logic signed [17:0] audio_l,
   input  logic signed [17:0] audio_r,
   input  video_pkg::volume_t volume,
   output logic               hp_bck,
   output logic               hp_ws,
   output logic               hp_din,
   output logic               pa_en
);

   localparam int DW = $clog2(AUDIO_DIV + 1);

   logic [DW-1:0]      div_cnt;
   logic [4:0]         bit_cnt;
   logic [15:0]        word;
   logic signed [15:0] sat_l;
   logic signed [15:0] sat_r;
   logic [15:0]        mixed;

   // drop two lsbs, clip to 16 bit signed
   function automatic logic signed [15:0] sat16(input logic signed [17:0] a);
      logic [16:0] t;
      t = {a[17], a[17:2]};
      if (t[16] != t[15]) begin
         return {t[16], {15{~t[16]}}};
      end
      return t[15:0];
   endfunction

   function automatic logic signed [15:0] scale(input logic signed [15:0] s,
                                                input logic [1:0] v);
      case (v)
         2'd0:    return 16'sd0;
         2'd1:    return s >>> 2;
         2'd2:    return s >>> 1;
         default: return s;
      endcase
   endfunction

   // mono sum wraps around
   assign mixed  = scale(sat_l, volume) + scale(sat_r, volume);
   assign hp_ws  = bit_cnt[4];
   assign hp_din = word[~bit_cnt[3:0]];

   always_ff @(posedge clk_pixel) begin
      sat_l <= sat16(audio_l);
      sat_r <= sat16(audio_r);
   end

   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         div_cnt <= '0;
         hp_bck  <= 1'b0;
         bit_cnt <= '0;
         word    <= '0;
         pa_en   <= 1'b0;
      end else begin
         pa_en <= 1'b1;
         if (div_cnt == DW'(AUDIO_DIV - 1)) begin
            div_cnt <= '0;
            hp_bck  <= ~hp_bck;
            // data moves on the falling bit clock
            if (hp_bck) begin
               bit_cnt <= bit_cnt + 5'd1;
               if (bit_cnt == 5'd31) begin
                  word <= mixed + 16'h8000;
               end
            end
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // word select flips only between the 16 bit halves
   a_ws_on_wrap: assert property (@(posedge clk_pixel) disable iff (!rst_n)
      $changed(hp_ws) |-> ($past(bit_cnt[3:0]) == 4'hf && bit_cnt[3:0] == 4'h0));

endmodule

// File: lcd_timing.sv
// places the lcd data-enable window on the doubled stream and drives the lcd pins
module lcd_timing #(
   parameter int H_ACTIVE = 800,
   parameter int V_ACTIVE = 480
) (
   input  logic              clk_pixel,
   input  logic              rst_n,
   pixel_if.sink             in,
   input  video_pkg::vmode_t vmode,
   output logic              lcd_clk,
   output logic              lcd_hs_n,
   output logic              lcd_vs_n,
   output logic              lcd_de,
   output logic [5:0]        lcd_r,
   output logic [5:0]        lcd_g,
   output logic [5:0]        lcd_b
);
   import video_pkg::*;

   logic        hs_q;
   logic        vs_q;
   logic        hs_rise;
   logic        vs_rise;
   logic [10:0] col_q;
   logic [10:0] col_cur;
   logic [9:0]  row_q;
   logic [9:0]  row_cur;
   logic [10:0] h_start;
   logic [9:0]  v_start;
   logic        de_cur;

   assign lcd_clk = clk_pixel;

   assign hs_rise = in.hs_n & ~hs_q;
   assign vs_rise = in.vs_n & ~vs_q;

   // position of the pixel currently on the stream
   assign col_cur = hs_rise ? 11'd0 : (col_q == 11'h7ff) ? col_q : col_q + 11'd1;
   assign row_cur = vs_rise ? 10'd0 : hs_rise ? row_q + 10'd1 : row_q;

   assign h_start = H_START_TABLE[vmode];
   assign v_start = V_START_TABLE[vmode];
   assign de_cur  = (col_cur >= h_start) && (col_cur < h_start + 11'(H_ACTIVE)) &&
                    (row_cur >= v_start) && (row_cur < v_start + 10'(V_ACTIVE));

   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         hs_q     <= 1'b1;
         vs_q     <= 1'b1;
         col_q    <= '0;
         row_q    <= '0;
         lcd_hs_n <= 1'b1;
         lcd_vs_n <= 1'b1;
         lcd_de   <= 1'b0;
      end else begin
         hs_q     <= in.hs_n;
         vs_q     <= in.vs_n;
         col_q    <= col_cur;
         row_q    <= row_cur;
         lcd_hs_n <= in.hs_n;
         lcd_vs_n <= in.vs_n;
         lcd_de   <= de_cur;
      end
   end

   // colours share the register stage with de
   always_ff @(posedge clk_pixel) begin
      lcd_r <= in.r;
      lcd_g <= in.g;
      lcd_b <= in.b;
   end

endmodule

// File: scan_doubler.sv
// two-line ping-pong buffer replaying each input line twice at double rate with scanline dimming
module scan_doubler #(
   parameter int LINE_AW = 11
) (
   input  logic                 clk_pixel,
   input  logic                 rst_n,
   input  logic                 hs_in_n,
   input  logic                 vs_in_n,
   input  logic [3:0]           r_in,
   input  logic [3:0]           g_in,
   input  logic [3:0]           b_in,
   input  video_pkg::scanline_t scanlines,
   pixel_if.source              out
);
   import video_pkg::*;

   localparam int CW = LINE_AW + 2;

   logic [17:0]      line_buf [2**(LINE_AW+1)];
   logic             hs_q;
   logic             hs_fall;
   logic             hs_rise;
   logic             pix_ce;
   logic             wr_bank;
   logic [LINE_AW:0] wr_addr;
   logic [CW-1:0]    in_cnt;
   logic [CW-1:0]    line_len;
   logic [CW-1:0]    hs_wid;
   logic [LINE_AW:0] half_len;
   logic [LINE_AW:0] hs_half;
   logic [LINE_AW:0] out_cnt;
   logic             replay;
   logic             vs_line_n;
   logic             vs_dly_n;
   logic [17:0]      rd_data;
   logic             hs_s1;
   logic             vs_s1;
   logic             dim_s1;

   // subtract a quarter, half or three quarters
   function automatic logic [5:0] dim6(input logic [5:0] c, input scanline_t lvl);
      case (lvl)
         2'd1:    return c - (c >> 2);
         2'd2:    return c - (c >> 1);
         2'd3:    return c - (c >> 1) - (c >> 2);
         default: return c;
      endcase
   endfunction

   assign hs_fall  = hs_q & ~hs_in_n;
   assign hs_rise  = ~hs_q & hs_in_n;
   assign half_len = line_len[CW-1:1];
   assign hs_half  = hs_wid[CW-1:1];

   // input side, line length and hsync width in clocks
   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         hs_q      <= 1'b1;
         pix_ce    <= 1'b0;
         wr_bank   <= 1'b0;
         wr_addr   <= '0;
         in_cnt    <= '0;
         line_len  <= '0;
         hs_wid    <= '0;
         vs_line_n <= 1'b1;
         vs_dly_n  <= 1'b1;
      end else begin
         hs_q <= hs_in_n;
         if (hs_fall) begin
            pix_ce    <= 1'b1;
            wr_addr   <= '0;
            wr_bank   <= ~wr_bank;
            in_cnt    <= CW'(1);
            line_len  <= in_cnt;
            vs_line_n <= vs_in_n;
            vs_dly_n  <= vs_line_n;
         end else begin
            pix_ce <= ~pix_ce;
            if (pix_ce) begin
               wr_addr <= wr_addr + 1'b1;
            end
            if (in_cnt != '1) begin
               in_cnt <= in_cnt + 1'b1;
            end
         end
         if (hs_rise) begin
            hs_wid <= in_cnt;
         end
      end
   end

   // buffer, write one half and read the other
   always_ff @(posedge clk_pixel) begin
      if (pix_ce && !hs_fall) begin
         line_buf[{wr_bank, wr_addr[LINE_AW-1:0]}] <=
            {expand4to6(r_in), expand4to6(g_in), expand4to6(b_in)};
      end
      rd_data <= line_buf[{~wr_bank, out_cnt[LINE_AW-1:0]}];
   end

   // output side at twice the pixel rate
   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         out_cnt  <= '0;
         replay   <= 1'b0;
         hs_s1    <= 1'b1;
         vs_s1    <= 1'b1;
         dim_s1   <= 1'b0;
         out.hs_n <= 1'b1;
         out.vs_n <= 1'b1;
         out.r    <= '0;
         out.g    <= '0;
         out.b    <= '0;
      end else begin
         if (hs_fall) begin
            out_cnt <= '0;
            replay  <= 1'b0;
         end else if (out_cnt == half_len - 1'b1) begin
            out_cnt <= '0;
            replay  <= 1'b1;
         end else begin
            out_cnt <= out_cnt + 1'b1;
         end
         // sync stage lines up with the buffer read
         hs_s1    <= (out_cnt >= hs_half);
         vs_s1    <= vs_dly_n;
         dim_s1   <= replay;
         out.hs_n <= hs_s1;
         out.vs_n <= vs_s1;
         out.r    <= dim6(rd_data[17:12], dim_s1 ? scanlines : 2'd0);
         out.g    <= dim6(rd_data[11:6], dim_s1 ? scanlines : 2'd0);
         out.b    <= dim6(rd_data[5:0], dim_s1 ? scanlines : 2'd0);
      end
   end

   // input lines must fit one buffer half
   a_wr_addr_range: assert property (@(posedge clk_pixel) disable iff (!rst_n)
      (pix_ce && !hs_fall) |-> !wr_addr[LINE_AW]);

endmodule

// File: video_mode_detect.sv
// classifies the incoming video mode from lines per frame and pulses vreset on a change
module video_mode_detect (
   input  logic             clk_pixel,
   input  logic             rst_n,
   input  logic             hs_n,
   input  logic             vs_n,
   output video_pkg::vmode_t vmode,
   output logic             vreset
);
   import video_pkg::*;

   logic       hs_q;
   logic       vs_q;
   logic       hs_fall;
   logic       vs_fall;
   logic [9:0] line_cnt;
   vmode_t     new_mode;

   assign hs_fall = hs_q & ~hs_n;
   assign vs_fall = vs_q & ~vs_n;

   // class of the frame that just ended
   assign new_mode = (line_cnt <= NTSC_MAX_LINES) ? VMODE_NTSC :
                     (line_cnt <= PAL_MAX_LINES)  ? VMODE_PAL  : VMODE_HIGH;

   always_ff @(posedge clk_pixel) begin
      if (!rst_n) begin
         hs_q     <= 1'b1;
         vs_q     <= 1'b1;
         line_cnt <= '0;
         vmode    <= VMODE_PAL;
         vreset   <= 1'b0;
      end else begin
         hs_q   <= hs_n;
         vs_q   <= vs_n;
         vreset <= 1'b0;
         if (vs_fall) begin
            // an hsync edge on the same clock opens the new frame
            line_cnt <= {9'd0, hs_fall};
            if (new_mode != vmode) begin
               vmode  <= new_mode;
               vreset <= 1'b1;
            end
         end else if (hs_fall && line_cnt != 10'h3ff) begin
            line_cnt <= line_cnt + 10'd1;
         end
      end
   end

   // frames must end before the line counter runs out
   a_line_cnt_no_sat: assert property (@(posedge clk_pixel) disable iff (!rst_n)
      (hs_fall && !vs_fall) |-> line_cnt != 10'h3ff);

endmodule

// File: pixel_if.sv
// doubled video stream between the scan doubler and the lcd timing block, runs every clock
interface pixel_if;

   logic       hs_n;
   logic       vs_n;
   logic [5:0] r;
   logic [5:0] g;
   logic [5:0] b;

   modport source (
      output hs_n, vs_n, r, g, b
   );

   modport sink (
      input hs_n, vs_n, r, g, b
   );

endinterface

// File: video_pkg.sv
// shared video and audio types, mode thresholds and lcd window tables for the output stage
package video_pkg;

   // incoming 15 kHz video mode
   typedef enum logic [1:0] {
      VMODE_NTSC = 2'd0,
      VMODE_PAL  = 2'd1,
      VMODE_HIGH = 2'd2
   } vmode_t;

   // 0 none, 1 keeps 3/4, 2 keeps 1/2, 3 keeps 1/4
   typedef logic [1:0] scanline_t;

   // 0 mute, 1 quarter, 2 half, 3 full
   typedef logic [1:0] volume_t;

   // input lines per frame
   localparam logic [9:0] NTSC_MAX_LINES = 10'd288;
   localparam logic [9:0] PAL_MAX_LINES  = 10'd400;

   // first active column and row, indexed by vmode_t
   localparam logic [10:0] H_START_TABLE [3] = '{11'd8, 11'd12, 11'd16};
   localparam logic [9:0]  V_START_TABLE [3] = '{10'd20, 10'd30, 10'd10};

   // 4 bit colour to 6 bits, top bits repeated below
   function automatic logic [5:0] expand4to6(input logic [3:0] c);
      return {c, c[3:2]};
   endfunction

endpackage
